// File: design/pt_walk_pkg.sv
// Page table walker package with table format constants, entry types and port structs
package pt_walk_pkg;

    // ==================================================
    // Table format
    // ==================================================

    // Each 4 KB table page holds 512 entries, so one level consumes 9 VA bits
    localparam int PT_IDX_W          = 9;
    localparam int PT_MAX_DEPTH      = 4;

    // A 512-bit host line carries 8 entries of 64 bits
    localparam int PT_ENTRY_W        = 64;
    localparam int LINE_DATA_W       = 512;
    localparam int PT_WORDS_PER_LINE = 8;
    localparam int PT_WORD_IDX_W     = 3;
    localparam int PT_LINE_IDX_W     = 6;

    // Physical 4 KB page index and line address widths
    localparam int PA_PAGE_W         = 36;
    localparam int LINE_ADDR_W       = 42;

    // Byte offset of a 4 KB page, where the next page field starts in an entry
    localparam int PT_PAGE_SHIFT     = 12;

    // ==================================================
    // Basic types
    // ==================================================

    typedef logic [PT_IDX_W-1:0] t_pt_idx;

    // Element 3 holds the root level index, taken from the top VA bits
    typedef t_pt_idx [PT_MAX_DEPTH-1:0] t_pt_idx_vec;

    typedef logic [$clog2(PT_MAX_DEPTH)-1:0] t_walk_depth;

    typedef logic [PT_IDX_W*PT_MAX_DEPTH-1:0] t_va_page;
    typedef logic [PA_PAGE_W-1:0]             t_pa_page;
    typedef logic [LINE_ADDR_W-1:0]           t_line_addr;
    typedef logic [LINE_DATA_W-1:0]           t_line_data;

    // ==================================================
    // Entry and port structs
    // ==================================================

    // Status bits of an entry
    // Bit 1 flags a missing translation, bit 0 a terminal entry
    typedef struct packed {
        logic error;
        logic terminal;
    } t_walk_status;

    // Decoded entry as seen by the control and address logic
    typedef struct packed {
        t_walk_status status;
        t_pa_page     next_page;
    } t_pt_entry_next;

    // Completed translation sent to the TLB
    typedef struct packed {
        t_va_page va;
        t_pa_page pa;
        logic     big_page;
    } t_tlb_fill;

    // Control registers seen by the walker
    typedef struct packed {
        logic     enable;
        logic     base_valid;
        t_pa_page base;
    } t_walk_csr;

endpackage

// File: design/pt_walk_ctrl.sv
// Page walk FSM issuing request, read and fill handshakes and datapath strobes
`timescale 1ns/1ps

module pt_walk_ctrl
    import pt_walk_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         csr_ok,
    input  logic         req_en,
    output logic         req_rdy,
    input  logic         read_rdy,
    output logic         read_en,
    input  logic         entry_valid,
    input  t_walk_status entry_status,
    input  t_walk_depth  depth,
    input  logic         fill_rdy,
    output logic         fill_en,
    output logic         big_page,
    output logic         walk_start,
    output logic         level_advance,
    output logic         page_load,
    output logic         not_present,
    output logic         busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_REQ,
        ST_WAIT_RSP,
        ST_DECIDE,
        ST_DONE,
        ST_ERROR
    } t_walk_state;

    t_walk_state state;

    // One-hot copies of idle and done keep the handshake paths short
    logic        state_is_idle;
    logic        state_is_done;

    // Table root is usable
    logic        initialized;

    // Decision terms for the current entry
    logic        last_level;
    logic        go_error;
    logic        go_done;

    // ==================================================
    // Decision logic
    // ==================================================

    assign last_level = (depth == t_walk_depth'(PT_MAX_DEPTH - 1));

    // Missing entry, or still not terminal at the deepest level
    assign go_error = entry_status.error || (!entry_status.terminal && last_level);
    assign go_done  = !go_error && entry_status.terminal;

    // ==================================================
    // Handshakes and strobes
    // ==================================================

    // Only one walk in flight
    assign req_rdy    = initialized && state_is_idle;
    assign walk_start = req_en && req_rdy;

    // Address stays put while read_rdy is low
    assign read_en    = (state == ST_READ_REQ) && read_rdy;

    assign fill_en    = state_is_done && fill_rdy;

    // Next page copied on every decision
    // After a terminal entry it becomes the translated page
    assign page_load     = (state == ST_DECIDE);
    assign level_advance = (state == ST_DECIDE) && !go_error && !go_done;

    assign busy = !state_is_idle;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            initialized <= 1'b0;
        end
        else
        begin
            initialized <= csr_ok;
        end
    end

    // ==================================================
    // State transitions
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= ST_IDLE;
            state_is_idle <= 1'b1;
            state_is_done <= 1'b0;
            not_present   <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (walk_start)
                    begin
                        state         <= ST_READ_REQ;
                        state_is_idle <= 1'b0;
                    end
                end

                ST_READ_REQ:
                begin
                    if (read_en)
                    begin
                        state <= ST_WAIT_RSP;
                    end
                end

                ST_WAIT_RSP:
                begin
                    // Registered entry of this level is ready
                    if (entry_valid)
                    begin
                        state <= ST_DECIDE;
                    end
                end

                ST_DECIDE:
                begin
                    if (go_error)
                    begin
                        state <= ST_ERROR;
                    end
                    else if (go_done)
                    begin
                        state         <= ST_DONE;
                        state_is_done <= 1'b1;
                    end
                    else
                    begin
                        state <= ST_READ_REQ;
                    end
                end

                ST_DONE:
                begin
                    if (fill_en)
                    begin
                        state         <= ST_IDLE;
                        state_is_idle <= 1'b1;
                        state_is_done <= 1'b0;
                    end
                end

                ST_ERROR:
                begin
                    // Held until reset
                    not_present <= 1'b1;
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Level 2 terminal maps a 2 MB page, level 3 a 4 KB page
    always_ff @(posedge clk)
    begin
        if (state == ST_DECIDE)
        begin
            big_page <= (depth == t_walk_depth'(PT_MAX_DEPTH - 2));
        end
    end

endmodule

// File: design/pt_va_index.sv
// VA capture with per-level index vector and walk depth counter
`timescale 1ns/1ps

module pt_va_index
    import pt_walk_pkg::*;
(
    input  logic        clk,
    input  logic        walk_start,
    input  logic        level_advance,
    input  t_va_page    req_va,
    output t_va_page    va,
    output t_pt_idx_vec idx_vec,
    output t_walk_depth depth
);

    // VA page split into 9-bit indices, root index in the top element
    t_pt_idx_vec req_idx_vec;

    assign req_idx_vec = req_va;

    // ==================================================
    // VA and depth
    // ==================================================

    // VA kept whole for the fill
    always_ff @(posedge clk)
    begin
        if (walk_start)
        begin
            va <= req_va;
        end
    end

    // Walk always starts at the root
    always_ff @(posedge clk)
    begin
        if (walk_start)
        begin
            depth <= '0;
        end
        else if (level_advance)
        begin
            depth <= depth + t_walk_depth'(1);
        end
    end

    // ==================================================
    // Index vector
    // ==================================================

    // Shift up one element per level so the live index stays on top
    always_ff @(posedge clk)
    begin
        if (walk_start)
        begin
            idx_vec <= req_idx_vec;
        end
        else if (level_advance)
        begin
            for (int i = PT_MAX_DEPTH - 1; i > 0; i--)
            begin
                idx_vec[i] <= idx_vec[i-1];
            end
            // Emptied bottom slot
            idx_vec[0] <= '0;
        end
    end

endmodule

// File: design/pt_page_addr.sv
// Current table page register and host line read address
`timescale 1ns/1ps

module pt_page_addr
    import pt_walk_pkg::*;
(
    input  logic       clk,
    input  logic       walk_start,
    input  logic       page_load,
    input  t_pa_page   root,
    input  t_pa_page   next_page,
    input  t_pt_idx    level_idx,
    output t_line_addr read_addr,
    output t_pa_page   pa
);

    // Page being read, or the translated page once the walk ends
    t_pa_page cur_page;

    // Line inside the page, from the upper index bits
    logic [PT_LINE_IDX_W-1:0] line_idx;

    always_ff @(posedge clk)
    begin
        if (walk_start)
        begin
            cur_page <= root;
        end
        else if (page_load)
        begin
            cur_page <= next_page;
        end
    end

    assign line_idx = level_idx[PT_IDX_W-1 -: PT_LINE_IDX_W];

    // Page index above the 64 lines of one page
    assign read_addr = {cur_page, line_idx};

    assign pa = cur_page;

endmodule

// File: design/pt_rsp_decode.sv
// Read response register stage with entry select and status and next page decode
`timescale 1ns/1ps

module pt_rsp_decode
    import pt_walk_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     read_data_en,
    input  t_line_data               read_data,
    input  logic [PT_WORD_IDX_W-1:0] word_idx,
    output t_pt_entry_next           entry,
    output logic                     entry_valid
);

    // ==================================================
    // Response register stage
    // ==================================================

    t_line_data line_q;

    // Line viewed as its 8 entries
    logic [PT_WORDS_PER_LINE-1:0][PT_ENTRY_W-1:0] line_words;
    logic [PT_ENTRY_W-1:0]                        word;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            entry_valid <= 1'b0;
        end
        else
        begin
            entry_valid <= read_data_en;
        end
    end

    // Line held until the next response so the decision sees a stable entry
    always_ff @(posedge clk)
    begin
        if (read_data_en)
        begin
            line_q <= read_data;
        end
    end

    // ==================================================
    // Entry select and decode
    // ==================================================

    assign line_words = line_q;
    assign word       = line_words[word_idx];

    // Unwritten entries are all ones, so bit 1 also catches them
    assign entry.status.error    = word[1];
    assign entry.status.terminal = word[0];
    assign entry.next_page       = word[PT_PAGE_SHIFT +: PA_PAGE_W];

endmodule

// File: design/pt_walk_top.sv
// Page table walker top level joining the walk FSM with the index, address and decode paths
`timescale 1ns/1ps

module pt_walk_top
    import pt_walk_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Control registers
    input  t_walk_csr  csr,

    // TLB miss request
    input  logic       req_en,
    input  t_va_page   req_va,
    output logic       req_rdy,

    // Host memory line reads
    input  logic       read_rdy,
    output logic       read_en,
    output t_line_addr read_addr,
    input  logic       read_data_en,
    input  t_line_data read_data,

    // TLB fill
    input  logic       fill_rdy,
    output logic       fill_en,
    output t_tlb_fill  fill,

    // Status
    output logic       not_present,
    output logic       busy
);

    // Walker may only run with a valid table root
    logic           csr_ok;

    // Strobes from the FSM
    logic           walk_start;
    logic           level_advance;
    logic           page_load;
    logic           big_page;

    // Walk context
    t_va_page       va;
    t_pt_idx_vec    idx_vec;
    t_walk_depth    depth;
    t_pa_page       pa;

    // Decoded entry of the current level
    t_pt_entry_next entry;
    logic           entry_valid;

    assign csr_ok = csr.enable && csr.base_valid;

    // ==================================================
    // Walk FSM
    // ==================================================

    pt_walk_ctrl u_pt_walk_ctrl (
        .clk           (clk),
        .reset         (reset),
        .csr_ok        (csr_ok),
        .req_en        (req_en),
        .req_rdy       (req_rdy),
        .read_rdy      (read_rdy),
        .read_en       (read_en),
        .entry_valid   (entry_valid),
        .entry_status  (entry.status),
        .depth         (depth),
        .fill_rdy      (fill_rdy),
        .fill_en       (fill_en),
        .big_page      (big_page),
        .walk_start    (walk_start),
        .level_advance (level_advance),
        .page_load     (page_load),
        .not_present   (not_present),
        .busy          (busy)
    );

    // ==================================================
    // Datapath
    // ==================================================

    pt_va_index u_pt_va_index (
        .clk           (clk),
        .walk_start    (walk_start),
        .level_advance (level_advance),
        .req_va        (req_va),
        .va            (va),
        .idx_vec       (idx_vec),
        .depth         (depth)
    );

    // Current level index always sits in the top element
    pt_page_addr u_pt_page_addr (
        .clk        (clk),
        .walk_start (walk_start),
        .page_load  (page_load),
        .root       (csr.base),
        .next_page  (entry.next_page),
        .level_idx  (idx_vec[PT_MAX_DEPTH-1]),
        .read_addr  (read_addr),
        .pa         (pa)
    );

    // Low index bits pick the entry inside the returned line
    pt_rsp_decode u_pt_rsp_decode (
        .clk          (clk),
        .reset        (reset),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .word_idx     (idx_vec[PT_MAX_DEPTH-1][PT_WORD_IDX_W-1:0]),
        .entry        (entry),
        .entry_valid  (entry_valid)
    );

    // Fill result
    assign fill = '{va: va, pa: pa, big_page: big_page};

endmodule

// File: test/tb_pt_memory.sv
// Host memory model holding page table lines and answering line reads after a random delay
`timescale 1ns/1ps

module tb_pt_memory
    import pt_walk_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       read_rdy,
    input  logic       read_en,
    input  t_line_addr read_addr,
    output logic       read_data_en,
    output t_line_data read_data
);

    // Sparse line store keyed by line address
    t_line_data lines [t_line_addr];

    // One read in flight, as the walker issues them
    logic       pending;
    t_line_addr pending_addr;
    int         pending_delay;

    initial
    begin
        read_rdy      = 1'b0;
        read_data_en  = 1'b0;
        read_data     = '0;
        pending       = 1'b0;
        pending_addr  = '0;
        pending_delay = 0;
    end

    // ==================================================
    // Table access for the testbench
    // ==================================================

    task automatic clear_lines();
        lines.delete();
    endtask

    // Unwritten lines read as all ones, which decodes as error
    function automatic t_line_data line_at(input t_line_addr addr);
        if (lines.exists(addr))
        begin
            return lines[addr];
        end
        return '1;
    endfunction

    // Entry write keeps the other words of the line
    task automatic write_entry(
        input t_line_addr               addr,
        input logic [PT_WORD_IDX_W-1:0] word_idx,
        input logic [PT_ENTRY_W-1:0]    value
    );
        t_line_data line;
        line = line_at(addr);
        line[word_idx*PT_ENTRY_W +: PT_ENTRY_W] = value;
        lines[addr] = line;
    endtask

    // ==================================================
    // Read port
    // ==================================================

    // Accepted read seen at the clock edge
    always @(posedge clk)
    begin
        if (!reset && read_en)
        begin
            pending       = 1'b1;
            pending_addr  = read_addr;
            pending_delay = $urandom_range(1, 8);
        end
    end

    // Response and ready driven on the falling edge
    always @(negedge clk)
    begin
        read_data_en = 1'b0;
        if (reset)
        begin
            pending = 1'b0;
        end
        else if (pending)
        begin
            pending_delay = pending_delay - 1;
            if (pending_delay == 0)
            begin
                read_data    = line_at(pending_addr);
                read_data_en = 1'b1;
                pending      = 1'b0;
            end
        end
        // Ready about three cycles in four
        read_rdy = ($urandom_range(0, 3) != 0);
    end

endmodule

// File: test/tb_pt_walk.sv
// Testbench for the page table walker with random tables and a reference walk
`timescale 1ns/1ps

module tb_pt_walk;
    import pt_walk_pkg::*;

    localparam int N_WALKS        = 48;
    localparam int TIMEOUT_CYCLES = (N_WALKS + 1) * 80;

    logic       clk;
    logic       reset;
    t_walk_csr  csr;
    logic       req_en;
    t_va_page   req_va;
    logic       req_rdy;
    logic       read_rdy;
    logic       read_en;
    t_line_addr read_addr;
    logic       read_data_en;
    t_line_data read_data;
    logic       fill_rdy;
    logic       fill_en;
    t_tlb_fill  fill;
    logic       not_present;
    logic       busy;

    // Reference state shared with the monitor
    t_line_addr exp_reads[$];
    t_tlb_fill  exp_fill;
    logic       fill_allowed;
    int         fill_count;
    int         resp_count;
    int         cycle_count;

    pt_walk_top u_pt_walk_top (
        .clk          (clk),
        .reset        (reset),
        .csr          (csr),
        .req_en       (req_en),
        .req_va       (req_va),
        .req_rdy      (req_rdy),
        .read_rdy     (read_rdy),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .fill_rdy     (fill_rdy),
        .fill_en      (fill_en),
        .fill         (fill),
        .not_present  (not_present),
        .busy         (busy)
    );

    tb_pt_memory u_mem (
        .clk          (clk),
        .reset        (reset),
        .read_rdy     (read_rdy),
        .read_en      (read_en),
        .read_addr    (read_addr),
        .read_data_en (read_data_en),
        .read_data    (read_data)
    );

    always #2 clk = ~clk;

    // ==================================================
    // Failure reporting and helpers
    // ==================================================

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // 36 random bits, used for VAs and table pages
    function automatic logic [35:0] rand36();
        logic [31:0] lo;
        logic [3:0]  hi;
        lo = $urandom;
        hi = $urandom_range(0, 15);
        return {hi, lo};
    endfunction

    // Entry with random filler around the next page and status fields
    function automatic logic [PT_ENTRY_W-1:0] make_entry(input t_pa_page next,
                                                         input logic err, input logic term);
        logic [15:0] top_bits;
        logic [9:0]  low_bits;
        top_bits = $urandom;
        low_bits = $urandom;
        return {top_bits, next, low_bits, err, term};
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset        = 1'b0;
        fill_allowed = 1'b0;
        exp_reads.delete();
    endtask

    // ==================================================
    // Monitor and timeout
    // ==================================================

    always @(posedge clk)
    begin
        t_line_addr exp_addr;
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            abort_run($sformatf("Timeout after %0d cycles, a walk never finished", cycle_count));
        end
        else if (!reset)
        begin
            if (read_en)
            begin
                if (exp_reads.size() == 0)
                begin
                    abort_run("Table read issued when no read was expected");
                end
                else if (!read_rdy)
                begin
                    abort_run("Table read issued while read_rdy was low");
                end
                else
                begin
                    exp_addr = exp_reads.pop_front();
                    check_value("read_addr", read_addr, exp_addr);
                end
            end
            if (read_data_en)
            begin
                resp_count++;
            end
            if (fill_en)
            begin
                if (!fill_allowed)
                begin
                    abort_run("TLB fill issued on a walk that should not fill");
                end
                else
                begin
                    check_value("fill.va", fill.va, exp_fill.va);
                    check_value("fill.pa", fill.pa, exp_fill.pa);
                    check_value("fill.big_page", fill.big_page, exp_fill.big_page);
                    fill_allowed = 1'b0;
                    fill_count++;
                end
            end
        end
    end

    // ==================================================
    // Tests
    // ==================================================

    // Requests stay blocked until enable and base_valid are both set
    task automatic check_gating();
        req_en = 1'b1;
        req_va = rand36();
        for (int i = 0; i < 15; i++)
        begin
            // Enable alone, then base_valid alone
            if (i == 5)
                csr = '{enable: 1'b1, base_valid: 1'b0, base: rand36()};
            if (i == 10)
                csr = '{enable: 1'b0, base_valid: 1'b1, base: rand36()};
            check_value("req_rdy", req_rdy, 1'b0);
            @(negedge clk);
        end
        req_en = 1'b0;
        csr    = '{enable: 1'b1, base_valid: 1'b1, base: rand36()};
        @(negedge clk);
        check_value("req_rdy", req_rdy, 1'b1);
    endtask

    // Kind 0 is 4 KB, 1 is 2 MB, 2 an error bit, 3 non-terminal at level 3
    task automatic run_walk(input int kind);
        t_va_page va;
        t_pa_page page [PT_MAX_DEPTH];
        t_pa_page next;
        t_pt_idx  idx;
        int       last;
        int       stall;
        int       fills_before;
        logic     err_bit;
        logic     term_bit;

        u_mem.clear_lines();
        va      = rand36();
        page[0] = rand36();
        last    = (kind == 1) ? 2 : (kind == 2) ? $urandom_range(0, 3) : 3;

        // Reference walk, root index from the top VA bits
        for (int d = 0; d <= last; d++)
        begin
            idx      = va[PT_IDX_W*(PT_MAX_DEPTH-d)-1 -: PT_IDX_W];
            next     = rand36();
            err_bit  = (kind == 2) && (d == last);
            term_bit = (d != last) ? 1'b0 : (kind < 2) ? 1'b1 :
                       (kind == 2) ? 1'($urandom_range(0, 1)) : 1'b0;
            u_mem.write_entry({page[d], idx[PT_IDX_W-1 -: PT_LINE_IDX_W]},
                              idx[PT_WORD_IDX_W-1:0], make_entry(next, err_bit, term_bit));
            exp_reads.push_back({page[d], idx[PT_IDX_W-1 -: PT_LINE_IDX_W]});
            if (d < PT_MAX_DEPTH - 1)
                page[d+1] = next;
            if (d == last)
                exp_fill = '{va: va, pa: next, big_page: (kind == 1)};
        end

        fill_allowed = (kind < 2);
        fills_before = fill_count;
        resp_count   = 0;
        stall        = $urandom_range(0, 5);
        csr.base     = page[0];
        fill_rdy     = (stall == 0);

        while (!req_rdy)
            @(negedge clk);
        req_en = 1'b1;
        req_va = va;
        @(negedge clk);
        req_en = 1'b0;
        req_va = rand36();

        // One walk in flight blocks new requests
        check_value("busy", busy, 1'b1);
        check_value("req_rdy", req_rdy, 1'b0);

        // Last response seen
        while (resp_count < last + 1)
            @(negedge clk);

        if (kind < 2)
        begin
            // Register stage, then decision
            repeat (2) @(negedge clk);
            for (int s = 0; s < stall; s++)
            begin
                check_value("fill_en", fill_en, 1'b0);
                check_value("fill", fill, exp_fill);
                @(negedge clk);
            end
            fill_rdy = 1'b1;
            while (fill_count == fills_before)
                @(negedge clk);
            fill_rdy = 1'($urandom_range(0, 1));
            check_value("busy", busy, 1'b0);
            check_value("req_rdy", req_rdy, 1'b1);
        end
        else
        begin
            while (!not_present)
                @(negedge clk);
            // Sticky error ignores new requests
            req_en = 1'b1;
            for (int h = 0; h < 6; h++)
            begin
                check_value("not_present", not_present, 1'b1);
                check_value("req_rdy", req_rdy, 1'b0);
                @(negedge clk);
            end
            req_en = 1'b0;
            apply_reset();
            check_value("not_present", not_present, 1'b0);
        end
    endtask

    initial
    begin
        void'($urandom(32'h596d_9f11));
        clk          = 1'b0;
        reset        = 1'b1;
        csr          = '0;
        req_en       = 1'b0;
        req_va       = '0;
        fill_rdy     = 1'b0;
        fill_allowed = 1'b0;
        fill_count   = 0;
        resp_count   = 0;
        cycle_count  = 0;

        apply_reset();
        check_gating();
        for (int i = 0; i < N_WALKS; i++)
        begin
            run_walk($urandom_range(0, 3));
        end
        repeat (4) @(negedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: flist.f
design/pt_walk_pkg.sv
design/pt_walk_ctrl.sv
design/pt_va_index.sv
design/pt_page_addr.sv
design/pt_rsp_decode.sv
design/pt_walk_top.sv
test/tb_pt_memory.sv
test/tb_pt_walk.sv
